// ==== Makefile ====
# Verilator build and run for the front end testbench

VERILATOR  ?= verilator
TOP        ?= frontend_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
RUN_ARGS   ?= +verilator+error+limit+100
PASS_MSG   ?= TEST PASSED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only if the pass message shows up in the output
run: build
	@out="$$(./$(SIM) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
hdl/frontend_pkg.sv
hdl/fetch_ctrl.sv
hdl/branch_counters.sv
hdl/target_buffer.sv
hdl/stage_if.sv
hdl/imem_rom.sv
hdl/frontend_top.sv
verification/tb_clock_gen.sv
verification/frontend_props.sv
verification/frontend_tb.sv

// ==== hdl/branch_counters.sv ====
// --------------------------------------------------
// Branch direction counters
// --------------------------------------------------

`timescale 1ns/1ps

module branch_counters (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0] lookup_pc_i,
    output logic                                taken_o,
    input  frontend_pkg::resolve_t              resolve_i
);

    localparam int unsigned IDX_HI = frontend_pkg::PRED_IDX_W + 2;

    // Two-bit saturating counters, upper bit is the prediction
    logic [1:0] counters [frontend_pkg::PRED_ENTRIES];

    logic [frontend_pkg::PRED_IDX_W-1:0] lookup_idx;
    logic [frontend_pkg::PRED_IDX_W-1:0] train_idx;
    logic [1:0]                          train_cur;
    logic [1:0]                          train_next;

    // Index by line address, the word within a line shares the entry
    assign lookup_idx = lookup_pc_i[IDX_HI:3];
    assign train_idx  = resolve_i.pc[IDX_HI:3];

    // Lookup path
    assign taken_o = counters[lookup_idx][1];

    // Saturating update
    assign train_cur = counters[train_idx];
    always_comb begin
        train_next = train_cur;
        if (resolve_i.taken) begin
            if (train_cur != 2'b11) begin
                train_next = train_cur + 2'd1;
            end
        end else begin
            if (train_cur != 2'b00) begin
                train_next = train_cur - 2'd1;
            end
        end
    end

    // Counters come up weakly not-taken
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < frontend_pkg::PRED_ENTRIES; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (resolve_i.valid) begin
            counters[train_idx] <= train_next;
        end
    end

endmodule

// ==== hdl/fetch_ctrl.sv ====
// --------------------------------------------------
// Fetch control FSM
// --------------------------------------------------

`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       stall_i,
    input  logic                       flush_i,
    output logic                       fetch_en_o,
    output logic                       recover_o,
    output frontend_pkg::fetch_state_t state_o
);

    frontend_pkg::fetch_state_t state_q;
    frontend_pkg::fetch_state_t state_cur;
    frontend_pkg::fetch_state_t state_d;

    // Effective state this cycle
    // Stall pulls RUN into HOLD without waiting for an edge
    always_comb begin
        case (state_q)
            frontend_pkg::BOOT:    state_cur = frontend_pkg::BOOT;
            frontend_pkg::RECOVER: state_cur = frontend_pkg::RECOVER;
            default:               state_cur = stall_i ? frontend_pkg::HOLD : frontend_pkg::RUN;
        endcase
    end

    // Next state, flush wins over everything
    always_comb begin
        state_d = state_cur;
        if (flush_i) begin
            state_d = frontend_pkg::RECOVER;
        end else begin
            case (state_cur)
                frontend_pkg::BOOT:    state_d = frontend_pkg::RUN;
                frontend_pkg::RECOVER: state_d = stall_i ? frontend_pkg::HOLD : frontend_pkg::RUN;
                default:               state_d = state_cur;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= frontend_pkg::BOOT;
        end else begin
            state_q <= state_d;
        end
    end

    // Fetch only in a clean RUN cycle
    assign fetch_en_o = (state_cur == frontend_pkg::RUN) && !flush_i;
    // Bubble cycle after a redirect
    assign recover_o  = (state_cur == frontend_pkg::RECOVER);
    assign state_o    = state_cur;

endmodule

// ==== hdl/frontend_pkg.sv ====
// --------------------------------------------------
// Front end shared definitions
// --------------------------------------------------

package frontend_pkg;

    // --------------------------------------------------
    // Widths and constants
    // --------------------------------------------------

    // Byte address width
    localparam int unsigned ADDR_WIDTH = 32;
    // Lanes per fetch, the line split assumes two
    localparam int unsigned FETCH_WIDTH = 2;

    localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h0000_0000;

    // addi x0,x0,0
    localparam logic [31:0] NOP_INST = 32'h0000_0013;

    // Instruction ROM size in 32-bit words
    localparam int unsigned ROM_WORDS = 256;
    localparam int unsigned ROM_IDX_W = $clog2(ROM_WORDS);

    // Predictor tables, indexed by line address bits 6..3
    localparam int unsigned PRED_ENTRIES = 16;
    localparam int unsigned PRED_IDX_W = $clog2(PRED_ENTRIES);
    // Tag covers the line address bits above the index
    localparam int unsigned TAG_WIDTH = ADDR_WIDTH - 3 - PRED_IDX_W;

    // --------------------------------------------------
    // Memory line
    // --------------------------------------------------

    // One 64-bit line, seen whole by the ROM or as two words by fetch
    typedef union packed {
        logic [63:0]                  dword;
        logic [FETCH_WIDTH-1:0][31:0] words;
    } mem_line_t;

    typedef enum logic {
        MEM_NONE = 1'b0,
        MEM_LOAD = 1'b1
    } mem_cmd_t;

    // --------------------------------------------------
    // Fetch packets
    // --------------------------------------------------

    // One lane toward dispatch, 97 bits
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] pc;
        logic [ADDR_WIDTH-1:0] npc;
        logic [31:0]           inst;
        logic                  valid;
    } if_packet_t;

    // Lane 0 in the low slot
    typedef if_packet_t [FETCH_WIDTH-1:0] fetch_bundle_t;

    // --------------------------------------------------
    // Prediction and resolve
    // --------------------------------------------------

    // Predictor to fetch, lane is the word slot of the branch in its line
    typedef struct packed {
        logic                  valid;
        logic                  taken;
        logic                  lane;
        logic [ADDR_WIDTH-1:0] target;
    } pred_t;

    // Execute to predictor, one strobe per resolved branch
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] pc;
        logic                  taken;
        logic [ADDR_WIDTH-1:0] target;
    } resolve_t;

    // Controller states
    typedef enum logic [1:0] {
        BOOT    = 2'd0,
        RUN     = 2'd1,
        HOLD    = 2'd2,
        RECOVER = 2'd3
    } fetch_state_t;

endpackage

// ==== hdl/frontend_top.sv ====
// --------------------------------------------------
// Front end top level
// --------------------------------------------------

`timescale 1ns/1ps

module frontend_top (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                stall_i,
    input  logic                                flush_i,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0] correct_pc_i,
    input  frontend_pkg::resolve_t              resolve_i,
    output frontend_pkg::fetch_bundle_t         packets_o,
    output frontend_pkg::mem_cmd_t              mem_cmd_o,
    output logic [frontend_pkg::ADDR_WIDTH-1:0] mem_addr_o
);

    logic                                fetch_en;
    logic                                recover;
    logic [frontend_pkg::ADDR_WIDTH-1:0] fetch_pc;
    logic                                btb_hit;
    logic                                btb_lane;
    logic [frontend_pkg::ADDR_WIDTH-1:0] btb_target;
    logic                                ctr_taken;
    frontend_pkg::pred_t                 pred;
    frontend_pkg::mem_line_t             mem_line;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------

    fetch_ctrl u_ctrl (
        .clock      (clock),
        .reset      (reset),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .fetch_en_o (fetch_en),
        .recover_o  (recover),
        .state_o    ()
    );

    // --------------------------------------------------
    // Predictor
    // --------------------------------------------------

    branch_counters u_ctr (
        .clock       (clock),
        .reset       (reset),
        .lookup_pc_i (fetch_pc),
        .taken_o     (ctr_taken),
        .resolve_i   (resolve_i)
    );

    target_buffer u_btb (
        .clock       (clock),
        .reset       (reset),
        .lookup_pc_i (fetch_pc),
        .hit_o       (btb_hit),
        .lane_o      (btb_lane),
        .target_o    (btb_target),
        .resolve_i   (resolve_i)
    );

    // BTB gives where, counters give whether
    assign pred.valid  = btb_hit;
    assign pred.taken  = ctr_taken;
    assign pred.lane   = btb_lane;
    assign pred.target = btb_target;

    // --------------------------------------------------
    // Fetch and memory
    // --------------------------------------------------

    stage_if u_if (
        .clock        (clock),
        .reset        (reset),
        .fetch_en_i   (fetch_en),
        .recover_i    (recover),
        .flush_i      (flush_i),
        .correct_pc_i (correct_pc_i),
        .pred_i       (pred),
        .mem_line_i   (mem_line),
        .mem_cmd_o    (mem_cmd_o),
        .mem_addr_o   (mem_addr_o),
        .pc_o         (fetch_pc),
        .packets_o    (packets_o)
    );

    imem_rom u_rom (
        .clock  (clock),
        .addr_i (mem_addr_o),
        .cmd_i  (mem_cmd_o),
        .line_o (mem_line)
    );

endmodule

// ==== hdl/imem_rom.sv ====
// --------------------------------------------------
// Instruction ROM model
// --------------------------------------------------

`timescale 1ns/1ps

module imem_rom (
    input  logic                                clock,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0] addr_i,
    input  frontend_pkg::mem_cmd_t              cmd_i,
    output frontend_pkg::mem_line_t             line_o
);

    localparam int unsigned AW = frontend_pkg::ADDR_WIDTH;
    localparam int unsigned IW = frontend_pkg::ROM_IDX_W;

    logic [31:0]   rom_words [frontend_pkg::ROM_WORDS];
    logic [IW-1:0] lo_idx;
    logic [IW-1:0] hi_idx;
    logic          in_range;

    // Word i is addi x0,x0,i, so every fetch is predictable
    for (genvar i = 0; i < frontend_pkg::ROM_WORDS; i++) begin : g_rom
        assign rom_words[i] = {12'(i), frontend_pkg::NOP_INST[19:0]};
    end

    // Both words of the addressed line
    assign lo_idx   = {addr_i[IW+1:3], 1'b0};
    assign hi_idx   = {addr_i[IW+1:3], 1'b1};
    assign in_range = (addr_i[AW-1:IW+2] == '0);

    always_comb begin
        line_o.dword = '0;
        if (cmd_i == frontend_pkg::MEM_LOAD && in_range) begin
            line_o.dword = {rom_words[hi_idx], rom_words[lo_idx]};
        end
    end

    // Out-of-range loads read back zero and are flagged
    always_ff @(posedge clock) begin
        if (cmd_i == frontend_pkg::MEM_LOAD && !in_range) begin
            $error("imem_rom: load outside ROM at %h", addr_i);
        end
    end

endmodule

// ==== hdl/stage_if.sv ====
// --------------------------------------------------
// Instruction fetch stage
// --------------------------------------------------

`timescale 1ns/1ps

module stage_if (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                fetch_en_i,
    input  logic                                recover_i,
    input  logic                                flush_i,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0] correct_pc_i,
    input  frontend_pkg::pred_t                 pred_i,
    input  frontend_pkg::mem_line_t             mem_line_i,
    output frontend_pkg::mem_cmd_t              mem_cmd_o,
    output logic [frontend_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    output logic [frontend_pkg::ADDR_WIDTH-1:0] pc_o,
    output frontend_pkg::fetch_bundle_t         packets_o
);

    localparam int unsigned AW = frontend_pkg::ADDR_WIDTH;
    localparam int unsigned FW = frontend_pkg::FETCH_WIDTH;

    logic [AW-1:0]         pc_q;
    logic [AW-1:0]         pc_next;
    logic [AW-1:0]         line_addr;
    logic                  pred_taken;
    logic                  fetch_ok;
    logic [FW-1:0]         lane_valid;
    logic [FW-1:0][31:0]   lane_inst;

    // --------------------------------------------------
    // PC register and next-PC select
    // --------------------------------------------------

    assign line_addr  = {pc_q[AW-1:3], 3'b000};
    assign pred_taken = pred_i.valid && pred_i.taken;

    // Flush, then predicted taken, then next line, else hold
    always_comb begin
        pc_next = pc_q;
        if (flush_i) begin
            pc_next = correct_pc_i;
        end else if (fetch_en_i) begin
            if (pred_taken) begin
                pc_next = pred_i.target;
            end else begin
                // Sequential step always lands on the next line
                pc_next = line_addr + AW'(8);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= frontend_pkg::RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // --------------------------------------------------
    // Memory request
    // --------------------------------------------------

    // Line aligned, ROM answers in the same cycle
    assign mem_addr_o = line_addr;
    assign mem_cmd_o  = fetch_en_i ? frontend_pkg::MEM_LOAD : frontend_pkg::MEM_NONE;

    // --------------------------------------------------
    // Lane build
    // --------------------------------------------------

    // No valid lanes on a redirect or in the bubble after it
    assign fetch_ok = fetch_en_i && !flush_i && !recover_i;

    // Lane 0 starts at the PC word, which may be the upper slot
    assign lane_inst[0] = mem_line_i.words[pc_q[2]];
    assign lane_inst[1] = mem_line_i.words[1];

    assign lane_valid[0] = fetch_ok;
    // Lane 1 needs the PC in the low slot and no taken branch at slot 0
    assign lane_valid[1] = fetch_ok
                        && !pc_q[2]
                        && !(pred_taken && (pred_i.lane == 1'b0));

    always_comb begin
        for (int k = 0; k < FW; k++) begin
            packets_o[k].pc    = pc_q + AW'(4 * k);
            packets_o[k].npc   = pc_q + AW'(4 * k + 4);
            packets_o[k].inst  = lane_valid[k] ? lane_inst[k] : frontend_pkg::NOP_INST;
            packets_o[k].valid = lane_valid[k];
        end
    end

endmodule

// ==== hdl/target_buffer.sv ====
// --------------------------------------------------
// Branch target buffer
// --------------------------------------------------

`timescale 1ns/1ps

module target_buffer (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0] lookup_pc_i,
    output logic                                hit_o,
    output logic                                lane_o,
    output logic [frontend_pkg::ADDR_WIDTH-1:0] target_o,
    input  frontend_pkg::resolve_t              resolve_i
);

    localparam int unsigned IDX_HI = frontend_pkg::PRED_IDX_W + 2;
    localparam int unsigned TAG_LO = frontend_pkg::PRED_IDX_W + 3;

    // Payload of one entry, valid bits are kept apart
    typedef struct packed {
        logic [frontend_pkg::TAG_WIDTH-1:0]  tag;
        logic                                lane;
        logic [frontend_pkg::ADDR_WIDTH-1:0] target;
    } btb_entry_t;

    logic [frontend_pkg::PRED_ENTRIES-1:0] entry_valid;
    btb_entry_t                            entries [frontend_pkg::PRED_ENTRIES];

    logic [frontend_pkg::PRED_IDX_W-1:0] lookup_idx;
    logic [frontend_pkg::TAG_WIDTH-1:0]  lookup_tag;
    logic [frontend_pkg::PRED_IDX_W-1:0] train_idx;
    btb_entry_t                          lookup_entry;
    btb_entry_t                          install_entry;

    // --------------------------------------------------
    // Lookup
    // --------------------------------------------------

    assign lookup_idx   = lookup_pc_i[IDX_HI:3];
    assign lookup_tag   = lookup_pc_i[frontend_pkg::ADDR_WIDTH-1:TAG_LO];
    assign lookup_entry = entries[lookup_idx];

    // Hit needs tag match and the branch slot at or after the fetch slot
    // A branch behind the fetch PC in the same line is not fetched
    assign hit_o    = entry_valid[lookup_idx]
                   && (lookup_entry.tag == lookup_tag)
                   && (lookup_entry.lane >= lookup_pc_i[2]);
    assign lane_o   = lookup_entry.lane;
    assign target_o = lookup_entry.target;

    // --------------------------------------------------
    // Training
    // --------------------------------------------------

    assign train_idx            = resolve_i.pc[IDX_HI:3];
    assign install_entry.tag    = resolve_i.pc[frontend_pkg::ADDR_WIDTH-1:TAG_LO];
    assign install_entry.lane   = resolve_i.pc[2];
    assign install_entry.target = resolve_i.target;

    // Only taken branches allocate, not-taken leaves direction to the counters
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (resolve_i.valid && resolve_i.taken) begin
            entry_valid[train_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (resolve_i.valid && resolve_i.taken) begin
            entries[train_idx] <= install_entry;
        end
    end

endmodule

// ==== verification/frontend_props.sv ====
// --------------------------------------------------
// Front end port properties
// --------------------------------------------------

`timescale 1ns/1ps

module frontend_props (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                stall_i,
    input  logic                                flush_i,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0] correct_pc_i,
    input  frontend_pkg::resolve_t              resolve_i,
    input  frontend_pkg::fetch_bundle_t         packets_i,
    input  frontend_pkg::mem_cmd_t              mem_cmd_i,
    input  logic [frontend_pkg::ADDR_WIDTH-1:0] mem_addr_i,
    input  frontend_pkg::fetch_state_t          state_i
);

    localparam int unsigned AW = frontend_pkg::ADDR_WIDTH;

    // Bumped by every failing assertion
    int fail_count = 0;

    // Last valid bundle, for advance checks
    logic          prev_valid;
    logic          prev_full;
    logic          prev_pred;
    logic [AW-1:0] prev_pc;
    logic          flush_gap;
    logic          first_seen;

    // Branch being trained and its direction runs, saturating at 2
    logic [AW-1:0] res_pc;
    logic [AW-1:0] res_target;
    logic [1:0]    taken_run;
    logic [1:0]    not_taken_run;
    logic          same_pc;
    logic          pred_hit;
    logic          valid0;
    logic          valid1;

    // ROM word i is NOP with i in the immediate field
    function automatic logic [31:0] rom_inst(input logic [AW-1:0] pc);
        return frontend_pkg::NOP_INST | (32'(pc >> 2) << 20);
    endfunction

    assign valid0   = packets_i[0].valid;
    assign valid1   = packets_i[1].valid;
    assign same_pc  = (resolve_i.pc == res_pc);
    // Two taken resolves in a row leave the counter at 10 or 11
    assign pred_hit = valid0 && (packets_i[0].pc == res_pc) && (taken_run == 2'd2);

    // --------------------------------------------------
    // Reference bookkeeping
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            prev_valid <= 1'b0;
            prev_full  <= 1'b0;
            prev_pred  <= 1'b0;
            prev_pc    <= '0;
            flush_gap  <= 1'b0;
            first_seen <= 1'b0;
        end else if (flush_i) begin
            flush_gap <= 1'b1;
        end else if (valid0) begin
            prev_valid <= 1'b1;
            prev_full  <= valid1;
            prev_pred  <= pred_hit;
            prev_pc    <= packets_i[0].pc;
            flush_gap  <= 1'b0;
            first_seen <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            res_pc        <= '0;
            res_target    <= '0;
            taken_run     <= 2'd0;
            not_taken_run <= 2'd0;
        end else if (resolve_i.valid) begin
            res_pc     <= resolve_i.pc;
            res_target <= resolve_i.target;
            if (resolve_i.taken) begin
                taken_run     <= (same_pc && taken_run != 2'd0) ? 2'd2 : 2'd1;
                not_taken_run <= 2'd0;
            end else begin
                not_taken_run <= (same_pc && not_taken_run != 2'd0) ? 2'd2 : 2'd1;
                taken_run     <= 2'd0;
            end
        end
    end

    // --------------------------------------------------
    // Reset, lanes and sequencing
    // --------------------------------------------------

    reset_idle: assert property (@(posedge clock)
        ((reset && $past(reset)) || state_i == frontend_pkg::BOOT)
        |-> (mem_cmd_i == frontend_pkg::MEM_NONE && !valid0 && !valid1))
        else begin fail_count++; $error("MISMATCH %0t: activity in reset or boot", $time); end

    first_pc: assert property (@(posedge clock) disable iff (reset)
        (valid0 && !first_seen) |-> packets_i[0].pc == frontend_pkg::RESET_PC)
        else begin fail_count++; $error("MISMATCH %0t: first pc %h", $time, packets_i[0].pc); end

    lane0_data: assert property (@(posedge clock) disable iff (reset)
        valid0 |-> (packets_i[0].inst == rom_inst(packets_i[0].pc)
                 && packets_i[0].npc == packets_i[0].pc + AW'(4)))
        else begin fail_count++; $error("MISMATCH %0t: lane 0 inst or npc", $time); end

    lane1_data: assert property (@(posedge clock) disable iff (reset)
        valid1 |-> (packets_i[1].inst == rom_inst(packets_i[1].pc)
                 && packets_i[1].npc == packets_i[1].pc + AW'(4)))
        else begin fail_count++; $error("MISMATCH %0t: lane 1 inst or npc", $time); end

    lane1_follows: assert property (@(posedge clock) disable iff (reset)
        valid1 |-> (valid0 && packets_i[1].pc == packets_i[0].pc + AW'(4)))
        else begin fail_count++; $error("MISMATCH %0t: lane 1 pc %h", $time, packets_i[1].pc); end

    // Request is a load of the line that holds the fetch PC
    mem_request: assert property (@(posedge clock) disable iff (reset)
        valid0 |-> (mem_cmd_i == frontend_pkg::MEM_LOAD
                 && mem_addr_i == (packets_i[0].pc & ~AW'(7))))
        else begin fail_count++; $error("MISMATCH %0t: request %h", $time, mem_addr_i); end

    // Holds across stalls too, a stall only delays the next line
    seq_advance: assert property (@(posedge clock) disable iff (reset)
        (valid0 && prev_valid && prev_full && !flush_gap) |-> packets_i[0].pc == prev_pc + AW'(8))
        else begin fail_count++; $error("MISMATCH %0t: pc %h after %h", $time,
            packets_i[0].pc, prev_pc); end

    // --------------------------------------------------
    // Stall and flush
    // --------------------------------------------------

    stall_idle: assert property (@(posedge clock) disable iff (reset)
        stall_i |-> (mem_cmd_i == frontend_pkg::MEM_NONE && !valid0 && !valid1))
        else begin fail_count++; $error("MISMATCH %0t: fetch during stall", $time); end

    flush_idle: assert property (@(posedge clock) disable iff (reset)
        (flush_i || $past(flush_i)) |-> (!valid0 && !valid1))
        else begin fail_count++; $error("MISMATCH %0t: valid lane in flush or bubble", $time); end

    flush_target: assert property (@(posedge clock) disable iff (reset)
        ($past(flush_i, 2) && !$past(flush_i) && !flush_i && !stall_i)
        |-> (valid0 && packets_i[0].pc == $past(correct_pc_i, 2)))
        else begin fail_count++; $error("MISMATCH %0t: redirect pc %h", $time, packets_i[0].pc); end

    // --------------------------------------------------
    // Prediction
    // --------------------------------------------------

    pred_cut: assert property (@(posedge clock) disable iff (reset)
        pred_hit |-> !valid1)
        else begin fail_count++; $error("MISMATCH %0t: lane 1 kept after taken branch", $time); end

    pred_target: assert property (@(posedge clock) disable iff (reset)
        (valid0 && prev_valid && prev_pred && !flush_gap) |-> packets_i[0].pc == res_target)
        else begin fail_count++; $error("MISMATCH %0t: predicted pc %h", $time, packets_i[0].pc); end

    pred_cleared: assert property (@(posedge clock) disable iff (reset)
        (valid0 && packets_i[0].pc == res_pc && not_taken_run == 2'd2) |-> valid1)
        else begin fail_count++; $error("MISMATCH %0t: lane 1 cut after not-taken", $time); end

endmodule

// ==== verification/frontend_tb.sv ====
// --------------------------------------------------
// Front end testbench
// --------------------------------------------------

`timescale 1ns/1ps

module frontend_tb;

    localparam logic [31:0] BRANCH_PC     = 32'h0000_0100;
    localparam logic [31:0] BRANCH_TARGET = 32'h0000_0180;

    logic                                clock;
    logic                                reset;
    logic                                stall;
    logic                                flush;
    logic [frontend_pkg::ADDR_WIDTH-1:0] correct_pc;
    frontend_pkg::resolve_t              resolve;
    frontend_pkg::fetch_bundle_t         packets;
    frontend_pkg::mem_cmd_t              mem_cmd;
    logic [frontend_pkg::ADDR_WIDTH-1:0] mem_addr;

    logic [7:0] lfsr_state;
    int         timeouts;
    int         value;
    int         hold;
    logic [31:0] target;

    tb_clock_gen u_clock (
        .clock_o (clock),
        .reset_o (reset)
    );

    frontend_top dut (
        .clock        (clock),
        .reset        (reset),
        .stall_i      (stall),
        .flush_i      (flush),
        .correct_pc_i (correct_pc),
        .resolve_i    (resolve),
        .packets_o    (packets),
        .mem_cmd_o    (mem_cmd),
        .mem_addr_o   (mem_addr)
    );

    // Properties see the ports and the controller state
    bind frontend_top frontend_props props (
        .clock        (clock),
        .reset        (reset),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .correct_pc_i (correct_pc_i),
        .resolve_i    (resolve_i),
        .packets_i    (packets_o),
        .mem_cmd_i    (mem_cmd_o),
        .mem_addr_i   (mem_addr_o),
        .state_i      (u_ctrl.state_o)
    );

    // --------------------------------------------------
    // Random bits
    // --------------------------------------------------

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic random_bits(input int count, output int bits);
        bits = 0;
        for (int i = 0; i < count; i++) begin
            bits       = {bits[30:0], lfsr_state[7]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // --------------------------------------------------
    // Waits, sampled on the falling edge
    // --------------------------------------------------

    task automatic wait_reset_release(input int limit);
        int cycles;
        cycles = 0;
        while (reset && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (reset) begin
            $display("ERROR at %0t: reset never released", $time);
            timeouts++;
        end
    endtask

    task automatic wait_for_fetch(input logic [31:0] addr, input int limit);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < limit) begin
            @(negedge clock);
            found = packets[0].valid && (packets[0].pc == addr);
            cycles++;
        end
        if (!found) begin
            $display("ERROR at %0t: no fetch at %h within %0d cycles", $time, addr, limit);
            timeouts++;
        end
    endtask

    task automatic wait_any_fetch(input int limit);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < limit) begin
            @(negedge clock);
            found = packets[0].valid;
            cycles++;
        end
        if (!found) begin
            $display("ERROR at %0t: fetch did not resume within %0d cycles", $time, limit);
            timeouts++;
        end
    endtask

    // --------------------------------------------------
    // Stimulus, driven on the rising edge
    // --------------------------------------------------

    task automatic idle_cycles(input int count);
        repeat (count) @(posedge clock);
    endtask

    task automatic apply_stall(input int len);
        @(posedge clock);
        stall <= 1'b1;
        repeat (len) @(posedge clock);
        stall <= 1'b0;
    endtask

    // Optional stall over the flush and bubble cycles
    task automatic apply_flush(input logic [31:0] addr, input logic with_stall);
        @(posedge clock);
        flush      <= 1'b1;
        correct_pc <= addr;
        stall      <= with_stall;
        @(posedge clock);
        flush <= 1'b0;
        @(posedge clock);
        stall <= 1'b0;
    endtask

    task automatic send_resolve(input logic [31:0] pc, input logic taken, input logic [31:0] dest);
        @(posedge clock);
        resolve.valid  <= 1'b1;
        resolve.pc     <= pc;
        resolve.taken  <= taken;
        resolve.target <= dest;
        @(posedge clock);
        resolve <= '0;
    endtask

    initial begin
        stall      = 1'b0;
        flush      = 1'b0;
        correct_pc = '0;
        resolve    = '0;
        lfsr_state = 8'd61;
        timeouts   = 0;

        wait_reset_release(20);
        wait_for_fetch(32'h0000_0040, 40);

        // Random stall lengths of 1 to 8 cycles
        for (int i = 0; i < 4; i++) begin
            random_bits(3, value);
            apply_stall(value + 1);
            wait_any_fetch(10);
            idle_cycles(2);
        end

        // Line-aligned redirects in the lower half of the ROM
        for (int i = 0; i < 4; i++) begin
            random_bits(6, value);
            random_bits(1, hold);
            target = 32'(value) << 3;
            apply_flush(target, hold[0]);
            wait_for_fetch(target, 10);
            idle_cycles(2);
        end

        // Train taken, then fetch through the branch line
        send_resolve(BRANCH_PC, 1'b1, BRANCH_TARGET);
        send_resolve(BRANCH_PC, 1'b1, BRANCH_TARGET);
        apply_flush(BRANCH_PC - 32'd16, 1'b0);
        wait_for_fetch(BRANCH_PC, 10);
        wait_for_fetch(BRANCH_TARGET, 10);

        // Train back to not-taken
        send_resolve(BRANCH_PC, 1'b0, BRANCH_TARGET);
        send_resolve(BRANCH_PC, 1'b0, BRANCH_TARGET);
        apply_flush(BRANCH_PC - 32'd16, 1'b0);
        wait_for_fetch(BRANCH_PC, 10);
        wait_for_fetch(BRANCH_PC + 32'd8, 10);
        idle_cycles(4);

        $display("Summary: assertion failures %0d, timeouts %0d",
                 dut.props.fail_count, timeouts);
        if (dut.props.fail_count == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
// --------------------------------------------------
// Testbench clock and reset
// --------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);

    // 10 ns period
    initial clock_o = 1'b0;
    always #5 clock_o = ~clock_o;

    // Reset held over the first two rising edges
    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clock_o);
        reset_o <= 1'b0;
    end

endmodule
